// File: logic/nic.sv
/*
 * NIC shell top level
 * Control block, host-to-network and network-to-host RPC
 * channels, packet counters and the RPC rate meter
 */
`timescale 1ns/1ps

module nic (
    input  logic               ccip_clk,
    input  logic               reset,

    // MMIO
    input  nic_pkg::mmio_req_t mmio_req,
    output nic_pkg::mmio_rsp_t mmio_rsp,

    // Host to network
    input  nic_pkg::rpc_t      rpc_in,
    output logic               rpc_in_credit,
    output nic_pkg::rpc_t      net_tx,
    input  logic               net_tx_credit,

    // Network to host
    input  nic_pkg::rpc_t      net_rx,
    output logic               net_rx_credit,
    output nic_pkg::rpc_t      rpc_out,
    input  logic               rpc_out_credit
);
    import nic_pkg::*;

    logic     running;
    logic     tx_overflow;
    logic     rx_overflow;
    cnt_sel_t cnt_sel;
    count_t   cnt_value;
    rate_t    rps;

    // ====================
    // Control
    // ====================
    nic_control u_control (
        .ccip_clk    (ccip_clk),
        .reset       (reset),
        .mmio_req    (mmio_req),
        .mmio_rsp    (mmio_rsp),
        .tx_overflow (tx_overflow),
        .rx_overflow (rx_overflow),
        .cnt_value   (cnt_value),
        .rps         (rps),
        .running     (running),
        .cnt_sel     (cnt_sel)
    );

    // ====================
    // RPC channels
    // ====================
    rpc_channel #(
        .INIT_CREDITS (NET_TX_CREDITS)
    ) u_tx_channel (
        .ccip_clk   (ccip_clk),
        .reset      (reset),
        .enable     (running),
        .in_item    (rpc_in),
        .in_credit  (rpc_in_credit),
        .out_item   (net_tx),
        .out_credit (net_tx_credit),
        .overflow   (tx_overflow)
    );

    rpc_channel #(
        .INIT_CREDITS (HOST_RX_CREDITS)
    ) u_rx_channel (
        .ccip_clk   (ccip_clk),
        .reset      (reset),
        .enable     (running),
        .in_item    (net_rx),
        .in_credit  (net_rx_credit),
        .out_item   (rpc_out),
        .out_credit (rpc_out_credit),
        .overflow   (rx_overflow)
    );

    // ====================
    // Statistics
    // ====================
    nic_counters u_counters (
        .ccip_clk      (ccip_clk),
        .reset         (reset),
        .rpc_in_valid  (rpc_in.valid),
        .net_out_valid (net_tx.valid),
        .net_in_valid  (net_rx.valid),
        .rpc_out_valid (rpc_out.valid),
        .overflow      (tx_overflow | rx_overflow),
        .cnt_sel       (cnt_sel),
        .cnt_value     (cnt_value)
    );

    nic_rate_meter u_rate_meter (
        .ccip_clk  (ccip_clk),
        .reset     (reset),
        .rpc_valid (rpc_in.valid),
        .rps       (rps)
    );

endmodule

// File: logic/nic_control.sv
/*
 * NIC control block
 * MMIO write decode, register file, one-cycle read response
 * and the init/start sequencer with sticky error status
 */
`timescale 1ns/1ps

module nic_control (
    input  logic               ccip_clk,
    input  logic               reset,
    input  nic_pkg::mmio_req_t mmio_req,
    output nic_pkg::mmio_rsp_t mmio_rsp,
    input  logic               tx_overflow,
    input  logic               rx_overflow,
    input  nic_pkg::count_t    cnt_value,
    input  nic_pkg::rate_t     rps,
    output logic               running,
    output nic_pkg::cnt_sel_t  cnt_sel
);
    import nic_pkg::*;

    logic                  start_wr;
    logic                  init_wr;
    logic                  sel_wr;
    logic                  start_q;
    logic                  start_next;
    logic [INIT_CNT_W-1:0] init_cnt;
    nic_state_t            state;
    nic_state_t            state_next;
    logic                  err_tx_q;
    logic                  err_rx_q;
    nic_status_t           status;
    logic                  rsp_valid;
    mmio_tid_t             rsp_tid;
    mmio_data_t            rsp_data;

    // ====================
    // Write decode
    // ====================
    assign start_wr = mmio_req.wr_valid && (mmio_req.address == ADDR_START);
    assign init_wr  = mmio_req.wr_valid && (mmio_req.address == ADDR_INIT);
    assign sel_wr   = mmio_req.wr_valid && (mmio_req.address == ADDR_CNT_SEL);

    // FSM sees a start write in the same cycle it lands
    assign start_next = start_wr ? mmio_req.data[0] : start_q;

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            start_q <= 1'b0;
            cnt_sel <= CNT_RPC_IN;
        end else begin
            start_q <= start_next;
            if (sel_wr) begin
                cnt_sel <= cnt_sel_t'(mmio_req.data[$bits(cnt_sel_t)-1:0]);
            end
        end
    end

    // ====================
    // Sequencer
    // ====================
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:    state_next = ST_IDLE;
            ST_INIT: begin
                if (init_cnt == '0) begin
                    state_next = ST_READY;
                end
            end
            ST_READY: begin
                if (start_next) begin
                    state_next = ST_RUNNING;
                end
            end
            ST_RUNNING: begin
                if (!start_next) begin
                    state_next = ST_READY;
                end
            end
            default:    state_next = ST_IDLE;
        endcase

        // Init restarts the sequence from any state
        if (init_wr) begin
            state_next = ST_INIT;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            init_cnt <= '0;
        end else begin
            state <= state_next;
            if (init_wr) begin
                init_cnt <= INIT_CNT_W'(INIT_CYCLES - 1);
            end else if ((state == ST_INIT) && (init_cnt != '0)) begin
                init_cnt <= init_cnt - 1'b1;
            end
        end
    end

    // Sticky until reset
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            err_tx_q <= 1'b0;
            err_rx_q <= 1'b0;
        end else begin
            err_tx_q <= err_tx_q | tx_overflow;
            err_rx_q <= err_rx_q | rx_overflow;
        end
    end

    always_comb begin
        status.ready      = (state == ST_READY) || (state == ST_RUNNING);
        status.running    = (state == ST_RUNNING);
        status.err_tx_ovf = err_tx_q;
        status.err_rx_ovf = err_rx_q;
        status.error      = err_tx_q | err_rx_q;
    end

    assign running = status.running;

    // ====================
    // Read response
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= mmio_req.rd_valid;
        end
    end

    always_ff @(posedge ccip_clk) begin
        rsp_tid <= mmio_req.tid;
        case (mmio_req.address)
            ADDR_DFH:       rsp_data <= DFH_VALUE;
            ADDR_AFU_ID_L:  rsp_data <= AFU_ID[63:0];
            ADDR_AFU_ID_H:  rsp_data <= AFU_ID[127:64];
            ADDR_STATUS:    rsp_data <= mmio_data_t'(status);
            ADDR_RPS:       rsp_data <= mmio_data_t'(rps);
            ADDR_CNT_VALUE: rsp_data <= cnt_value;
            default:        rsp_data <= '0;
        endcase
    end

    assign mmio_rsp.valid = rsp_valid;
    assign mmio_rsp.tid   = rsp_tid;
    assign mmio_rsp.data  = rsp_data;

endmodule

// File: logic/nic_counters.sv
/*
 * NIC packet counters
 * Counts registered event strobes and presents the selected one
 */
`timescale 1ns/1ps

module nic_counters (
    input  logic              ccip_clk,
    input  logic              reset,
    input  logic              rpc_in_valid,
    input  logic              net_out_valid,
    input  logic              net_in_valid,
    input  logic              rpc_out_valid,
    input  logic              overflow,
    input  nic_pkg::cnt_sel_t cnt_sel,
    output nic_pkg::count_t   cnt_value
);
    import nic_pkg::*;

    logic [NUM_COUNTERS-1:0] event_q;
    count_t                  cnt_q    [NUM_COUNTERS];
    count_t                  cnt_next [NUM_COUNTERS];

    // Bit position matches the counter selector
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            event_q <= '0;
        end else begin
            event_q <= {overflow, rpc_out_valid, net_in_valid, net_out_valid, rpc_in_valid};
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            cnt_next[i] = cnt_q[i] + count_t'(event_q[i]);
        end
    end

    // Read-out taken from the next values to save a cycle
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                cnt_q[i] <= '0;
            end
            cnt_value <= '0;
        end else begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                cnt_q[i] <= cnt_next[i];
            end
            case (cnt_sel)
                CNT_RPC_IN:   cnt_value <= cnt_next[CNT_RPC_IN];
                CNT_NET_OUT:  cnt_value <= cnt_next[CNT_NET_OUT];
                CNT_NET_IN:   cnt_value <= cnt_next[CNT_NET_IN];
                CNT_RPC_OUT:  cnt_value <= cnt_next[CNT_RPC_OUT];
                CNT_OVERFLOW: cnt_value <= cnt_next[CNT_OVERFLOW];
                default:      cnt_value <= '0;
            endcase
        end
    end

endmodule

// File: logic/nic_pkg.sv
/*
 * NIC shell shared definitions
 * Widths, MMIO register map, sizing constants, port structs
 * and the init/start sequencer states
 */
package nic_pkg;

    // ====================
    // Widths
    // ====================
    typedef logic [15:0]  mmio_addr_t;   // 32-bit word units
    typedef logic [63:0]  mmio_data_t;
    typedef logic [8:0]   mmio_tid_t;
    typedef logic [511:0] rpc_data_t;    // One cache line
    typedef logic [3:0]   flow_id_t;
    typedef logic [63:0]  count_t;
    typedef logic [31:0]  rate_t;
    typedef logic [2:0]   cnt_sel_t;

    // ====================
    // Constants
    // ====================
    localparam logic [127:0] AFU_ID = 128'h5e9b_c1f0_7d32_4a86_b10e_93c4_28f7_a615;

    // Feature type AFU, end of feature list
    localparam mmio_data_t DFH_VALUE = 64'h1000_0100_0000_0000;

    // Register map, 64-bit registers on even word addresses
    localparam mmio_addr_t ADDR_DFH       = 16'd0;
    localparam mmio_addr_t ADDR_AFU_ID_L  = 16'd2;
    localparam mmio_addr_t ADDR_AFU_ID_H  = 16'd4;
    localparam mmio_addr_t ADDR_START     = 16'd16;
    localparam mmio_addr_t ADDR_INIT      = 16'd18;
    localparam mmio_addr_t ADDR_STATUS    = 16'd20;
    localparam mmio_addr_t ADDR_RPS       = 16'd22;
    localparam mmio_addr_t ADDR_CNT_SEL   = 16'd24;
    localparam mmio_addr_t ADDR_CNT_VALUE = 16'd26;

    localparam int INIT_CYCLES       = 4;
    localparam int INIT_CNT_W        = $clog2(INIT_CYCLES);
    localparam int RPS_WINDOW_CYCLES = 256;
    localparam int RPS_WIN_W         = $clog2(RPS_WINDOW_CYCLES);

    localparam int RPC_FIFO_DEPTH  = 8;
    localparam int FIFO_PTR_W      = $clog2(RPC_FIFO_DEPTH);
    localparam int FIFO_CNT_W      = $clog2(RPC_FIFO_DEPTH + 1);
    localparam int NET_TX_CREDITS  = 4;
    localparam int HOST_RX_CREDITS = 4;

    // Counter selectors
    localparam int       NUM_COUNTERS = 5;
    localparam cnt_sel_t CNT_RPC_IN   = 3'd0;
    localparam cnt_sel_t CNT_NET_OUT  = 3'd1;
    localparam cnt_sel_t CNT_NET_IN   = 3'd2;
    localparam cnt_sel_t CNT_RPC_OUT  = 3'd3;
    localparam cnt_sel_t CNT_OVERFLOW = 3'd4;

    // ====================
    // Port structs
    // ====================
    typedef struct packed {
        logic       wr_valid;
        logic       rd_valid;
        mmio_addr_t address;
        mmio_tid_t  tid;
        mmio_data_t data;
    } mmio_req_t;

    typedef struct packed {
        logic       valid;
        mmio_tid_t  tid;
        mmio_data_t data;
    } mmio_rsp_t;

    typedef struct packed {
        logic      valid;
        flow_id_t  flow_id;
        rpc_data_t data;
    } rpc_t;

    typedef struct packed {
        logic ready;
        logic running;
        logic err_tx_ovf;
        logic err_rx_ovf;
        logic error;
    } nic_status_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INIT,
        ST_READY,
        ST_RUNNING
    } nic_state_t;

endpackage

// File: logic/nic_rate_meter.sv
/*
 * RPC rate meter
 * Counts host RPCs over a fixed window of cycles
 */
`timescale 1ns/1ps

module nic_rate_meter (
    input  logic           ccip_clk,
    input  logic           reset,
    input  logic           rpc_valid,
    output nic_pkg::rate_t rps
);
    import nic_pkg::*;

    logic [RPS_WIN_W-1:0] win_cnt;
    rate_t                evt_cnt;
    logic                 win_end;

    assign win_end = (win_cnt == RPS_WIN_W'(RPS_WINDOW_CYCLES - 1));

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            win_cnt <= '0;
            evt_cnt <= '0;
            rps     <= '0;
        end else if (win_end) begin
            // Last cycle of the window still counts
            rps     <= evt_cnt + rate_t'(rpc_valid);
            evt_cnt <= '0;
            win_cnt <= '0;
        end else begin
            evt_cnt <= evt_cnt + rate_t'(rpc_valid);
            win_cnt <= win_cnt + 1'b1;
        end
    end

endmodule

// File: logic/rpc_channel.sv
/*
 * Credit-managed RPC channel
 * Queues incoming items and forwards them while enabled and
 * while downstream credit remains
 */
`timescale 1ns/1ps

module rpc_channel #(
    parameter int INIT_CREDITS = 4
) (
    input  logic          ccip_clk,
    input  logic          reset,
    input  logic          enable,
    input  nic_pkg::rpc_t in_item,
    output logic          in_credit,
    output nic_pkg::rpc_t out_item,
    input  logic          out_credit,
    output logic          overflow
);
    import nic_pkg::*;

    localparam int CRD_W = $clog2(INIT_CREDITS + 1);

    rpc_t                  mem [RPC_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] fifo_cnt;
    logic [CRD_W-1:0]      credits;
    logic                  full;
    logic                  push;
    logic                  pop;
    logic                  out_valid_q;
    flow_id_t              out_flow_q;
    rpc_data_t             out_data_q;

    assign full = (fifo_cnt == FIFO_CNT_W'(RPC_FIFO_DEPTH));
    assign push = in_item.valid && !full;
    assign pop  = enable && (fifo_cnt != '0) && (credits != '0);

    // Storage
    always_ff @(posedge ccip_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
        out_flow_q <= mem[rd_ptr].flow_id;
        out_data_q <= mem[rd_ptr].data;
    end

    // ====================
    // FIFO and credit control
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fifo_cnt    <= '0;
            credits     <= CRD_W'(INIT_CREDITS);
            out_valid_q <= 1'b0;
            in_credit   <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + FIFO_CNT_W'(push) - FIFO_CNT_W'(pop);

            // One credit spent per item sent, one back per downstream pulse
            credits <= credits - CRD_W'(pop) + CRD_W'(out_credit);

            out_valid_q <= pop;
            in_credit   <= pop;
            overflow    <= in_item.valid && full;
        end
    end

    assign out_item.valid   = out_valid_q;
    assign out_item.flow_id = out_flow_q;
    assign out_item.data    = out_data_q;

endmodule

// File: nic.f
+incdir+testbench
logic/nic_pkg.sv
logic/nic_control.sv
logic/rpc_channel.sv
logic/nic_counters.sv
logic/nic_rate_meter.sv
logic/nic.sv
testbench/tb_nic.sv

// File: testbench/tb_nic_tasks.svh
/*
 * NIC testbench tasks
 * MMIO access, host and network stimulus, typed compares
 * and the directed tests
 */
`ifndef TB_NIC_TASKS_SVH
`define TB_NIC_TASKS_SVH

// ====================
// Compares
// ====================
task automatic note_failure(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
endtask

task automatic check_data(input string name, input mmio_data_t got, input mmio_data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_tid(input string name, input mmio_tid_t got, input mmio_tid_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_rpc(input string name, input rpc_t got, input rpc_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_status(input string name, input nic_status_t got, input nic_status_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_count(input string name, input count_t got, input count_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic report_test(input string name, input int start_err);
    $display("Test %s finished with %0d errors", name, errors - start_err);
endtask

// ====================
// MMIO access
// ====================
task automatic mmio_write(input mmio_addr_t addr, input mmio_data_t data);
    mmio_req_t req;
    req          = '0;
    req.wr_valid = 1'b1;
    req.address  = addr;
    req.data     = data;
    @(posedge ccip_clk);
    mmio_req <= req;
    @(posedge ccip_clk);
    mmio_req.wr_valid <= 1'b0;
endtask

// Response must come exactly one cycle after the request
task automatic mmio_read(input mmio_addr_t addr, output mmio_data_t data);
    mmio_req_t req;
    mmio_tid_t tid;
    tid          = next_tid;
    next_tid     = next_tid + 1'b1;
    req          = '0;
    req.rd_valid = 1'b1;
    req.address  = addr;
    req.tid      = tid;
    @(posedge ccip_clk);
    mmio_req <= req;
    @(negedge ccip_clk);
    if (mmio_rsp.valid) begin
        note_failure($sformatf("MMIO response came early for address %0d", addr));
    end
    @(posedge ccip_clk);
    mmio_req.rd_valid <= 1'b0;
    @(negedge ccip_clk);
    if (!mmio_rsp.valid) begin
        note_failure($sformatf("no MMIO response one cycle after read of address %0d", addr));
    end
    check_tid("mmio_rsp.tid", mmio_rsp.tid, tid);
    data = mmio_rsp.data;
endtask

task automatic read_status(output nic_status_t status);
    mmio_data_t data;
    mmio_read(ADDR_STATUS, data);
    check_data("status upper bits", data & ~mmio_data_t'(5'h1f), '0);
    status = nic_status_t'(data[4:0]);
endtask

task automatic read_counter(input cnt_sel_t sel, output count_t value);
    mmio_data_t data;
    mmio_write(ADDR_CNT_SEL, mmio_data_t'(sel));
    mmio_read(ADDR_CNT_VALUE, data);
    value = count_t'(data);
endtask

// ====================
// Item traffic
// ====================
function automatic rpc_t random_rpc();
    rpc_t item;
    item.valid   = 1'b1;
    item.flow_id = flow_id_t'($urandom());
    for (int w = 0; w < 16; w++) begin
        item.data[w*32 +: 32] = $urandom();
    end
    return item;
endfunction

task automatic idle(input int cycles);
    repeat (cycles) @(posedge ccip_clk);
endtask

task automatic send_rpc_in(input rpc_t item, input bit use_credit);
    int waited;
    waited = 0;
    while (use_credit && host_credits == 0 && waited < ITEM_WAIT_LIMIT) begin
        @(negedge ccip_clk);
        waited++;
    end
    if (use_credit && host_credits == 0) begin
        note_failure("NIC returned no rpc_in credit");
    end
    @(posedge ccip_clk);
    rpc_in <= item;
    if (use_credit) begin
        host_credits--;
    end
    rpc_in_sent++;
    @(posedge ccip_clk);
    rpc_in.valid <= 1'b0;
endtask

task automatic send_net_rx(input rpc_t item);
    int waited;
    waited = 0;
    while (net_credits == 0 && waited < ITEM_WAIT_LIMIT) begin
        @(negedge ccip_clk);
        waited++;
    end
    if (net_credits == 0) begin
        note_failure("NIC returned no net_rx credit");
    end
    @(posedge ccip_clk);
    net_rx <= item;
    net_credits--;
    net_rx_sent++;
    @(posedge ccip_clk);
    net_rx.valid <= 1'b0;
endtask

task automatic return_net_credits(input int n);
    repeat (n) begin
        @(posedge ccip_clk);
        net_tx_credit <= 1'b1;
        @(posedge ccip_clk);
        net_tx_credit <= 1'b0;
    end
endtask

task automatic return_host_credits(input int n);
    repeat (n) begin
        @(posedge ccip_clk);
        rpc_out_credit <= 1'b1;
        @(posedge ccip_clk);
        rpc_out_credit <= 1'b0;
    end
endtask

task automatic wait_net_items(input int n);
    int waited;
    waited = 0;
    while (net_q.size() < n && waited < ITEM_WAIT_LIMIT) begin
        @(negedge ccip_clk);
        waited++;
    end
    if (net_q.size() < n) begin
        note_failure($sformatf("only %0d of %0d items seen on net_tx", net_q.size(), n));
    end
endtask

task automatic wait_host_items(input int n);
    int waited;
    waited = 0;
    while (host_q.size() < n && waited < ITEM_WAIT_LIMIT) begin
        @(negedge ccip_clk);
        waited++;
    end
    if (host_q.size() < n) begin
        note_failure($sformatf("only %0d of %0d items seen on rpc_out", host_q.size(), n));
    end
endtask

// ====================
// Directed tests
// ====================
task automatic test_identification();
    int         start_err;
    mmio_data_t data;
    start_err = errors;
    mmio_read(ADDR_DFH, data);
    // AFU feature type in the top nibble, end of list at bit 40
    check_data("dfh", data, (64'h1 << 60) | (64'h1 << 40));
    mmio_read(ADDR_AFU_ID_L, data);
    check_data("afu_id_l", data, AFU_ID[63:0]);
    mmio_read(ADDR_AFU_ID_H, data);
    check_data("afu_id_h", data, AFU_ID[127:64]);
    mmio_read(16'h0040, data);
    check_data("unmapped read", data, '0);
    report_test("identification", start_err);
endtask

task automatic test_sequencing();
    int          start_err;
    nic_status_t got;
    nic_status_t exp;
    bit          ready_seen;
    start_err = errors;
    read_status(got);
    check_status("status after reset", got, '0);
    mmio_write(ADDR_INIT, 64'h1);
    ready_seen = 1'b0;
    for (int i = 0; i < 10 && !ready_seen; i++) begin
        read_status(got);
        ready_seen = got.ready;
    end
    if (!ready_seen) begin
        note_failure("status never showed ready after init");
    end
    mmio_write(ADDR_START, 64'h1);
    read_status(got);
    exp         = '0;
    exp.ready   = 1'b1;
    exp.running = 1'b1;
    check_status("status after start", got, exp);
    mmio_write(ADDR_START, 64'h0);
    read_status(got);
    exp.running = 1'b0;
    check_status("status after stop", got, exp);
    report_test("sequencing", start_err);
endtask

task automatic test_tx_path();
    int   start_err;
    rpc_t item;
    start_err = errors;
    for (int i = 0; i < TX_ITEMS; i++) begin
        item = random_rpc();
        tx_expect.push_back(item);
        send_rpc_in(item, 1'b1);
    end
    idle(10);
    check_count("net_tx items before start", count_t'(net_q.size()), '0);
    mmio_write(ADDR_START, 64'h1);
    wait_net_items(NET_TX_CREDITS);
    idle(10);
    check_count("net_tx items without credit", count_t'(net_q.size()), NET_TX_CREDITS);
    return_net_credits(NET_TX_CREDITS);
    wait_net_items(TX_ITEMS);
    // Give back credits for the second batch too
    return_net_credits(TX_ITEMS - NET_TX_CREDITS);
    for (int i = 0; i < TX_ITEMS; i++) begin
        check_rpc("net_tx", net_q[i], tx_expect[i]);
    end
    check_count("rpc_in_credit pulses", count_t'(rpc_in_credit_cnt), TX_ITEMS);
    report_test("tx path", start_err);
endtask

task automatic test_rx_path();
    int   start_err;
    rpc_t item;
    start_err = errors;
    for (int i = 0; i < RX_ITEMS; i++) begin
        item = random_rpc();
        rx_expect.push_back(item);
        send_net_rx(item);
    end
    wait_host_items(HOST_RX_CREDITS);
    idle(10);
    check_count("rpc_out outstanding", count_t'(host_q.size()), HOST_RX_CREDITS);
    return_host_credits(HOST_RX_CREDITS);
    wait_host_items(RX_ITEMS);
    return_host_credits(RX_ITEMS - HOST_RX_CREDITS);
    idle(4);
    for (int i = 0; i < RX_ITEMS; i++) begin
        check_rpc("rpc_out", host_q[i], rx_expect[i]);
    end
    check_count("net_rx_credit pulses", count_t'(net_rx_credit_cnt), count_t'(RX_ITEMS));
    report_test("rx path", start_err);
endtask

task automatic test_counters();
    int          start_err;
    nic_status_t got;
    nic_status_t exp;
    count_t      value;
    start_err = errors;
    mmio_write(ADDR_START, 64'h0);
    // One item more than the FIFO holds, sent without credits
    for (int i = 0; i < RPC_FIFO_DEPTH + 1; i++) begin
        send_rpc_in(random_rpc(), 1'b0);
    end
    idle(4);
    read_counter(CNT_OVERFLOW, value);
    check_count("overflow count", value, 1);
    read_status(got);
    exp            = '0;
    exp.ready      = 1'b1;
    exp.err_tx_ovf = 1'b1;
    exp.error      = 1'b1;
    check_status("status after overflow", got, exp);
    read_counter(CNT_RPC_IN, value);
    check_count("rpc_in count", value, count_t'(rpc_in_sent));
    read_counter(CNT_NET_OUT, value);
    check_count("net_tx count", value, count_t'(TX_ITEMS));
    read_counter(CNT_NET_IN, value);
    check_count("net_rx count", value, count_t'(net_rx_sent));
    read_counter(CNT_RPC_OUT, value);
    check_count("rpc_out count", value, count_t'(RX_ITEMS));
    report_test("counters", start_err);
endtask

task automatic test_rate();
    int         start_err;
    mmio_data_t data;
    start_err = errors;
    // Start a few cycles into a window so every item lands in it
    while (run_cycles % RPS_WINDOW_CYCLES != 8) begin
        @(negedge ccip_clk);
    end
    for (int i = 0; i < RATE_ITEMS; i++) begin
        send_rpc_in(random_rpc(), 1'b0);
    end
    while (run_cycles % RPS_WINDOW_CYCLES != 4) begin
        @(negedge ccip_clk);
    end
    mmio_read(ADDR_RPS, data);
    check_data("rps after busy window", data, RATE_ITEMS);
    idle(2 * RPS_WINDOW_CYCLES);
    mmio_read(ADDR_RPS, data);
    check_data("rps after idle window", data, '0);
    report_test("rate", start_err);
endtask

`endif

// File: testbench/tb_nic.sv
/*
 * NIC shell testbench
 * Clock, reset, DUT, host and network models, test sequence
 */
`timescale 1ns/1ps

module tb_nic;
    import nic_pkg::*;

    localparam int CLK_PERIOD      = 100;
    // Rate test spans about four windows, the rest a few hundred cycles
    localparam int TIMEOUT_CYCLES  = 4000;
    localparam int ITEM_WAIT_LIMIT = 50;
    localparam int TX_ITEMS        = RPC_FIFO_DEPTH;
    localparam int RX_ITEMS        = 6;
    localparam int RATE_ITEMS      = 5;

    logic      ccip_clk;
    logic      reset;
    mmio_req_t mmio_req;
    mmio_rsp_t mmio_rsp;
    rpc_t      rpc_in;
    logic      rpc_in_credit;
    rpc_t      net_tx;
    logic      net_tx_credit;
    rpc_t      net_rx;
    logic      net_rx_credit;
    rpc_t      rpc_out;
    logic      rpc_out_credit;

    int        errors;
    int        checks;
    int        cycle_cnt;
    int        run_cycles;
    int        host_credits;
    int        net_credits;
    int        rpc_in_sent;
    int        net_rx_sent;
    int        rpc_in_credit_cnt;
    int        net_rx_credit_cnt;
    mmio_tid_t next_tid;

    // Items seen on the DUT outputs and items expected there
    rpc_t      net_q[$];
    rpc_t      host_q[$];
    rpc_t      tx_expect[$];
    rpc_t      rx_expect[$];

    `include "tb_nic_tasks.svh"

    nic u_nic (
        .ccip_clk       (ccip_clk),
        .reset          (reset),
        .mmio_req       (mmio_req),
        .mmio_rsp       (mmio_rsp),
        .rpc_in         (rpc_in),
        .rpc_in_credit  (rpc_in_credit),
        .net_tx         (net_tx),
        .net_tx_credit  (net_tx_credit),
        .net_rx         (net_rx),
        .net_rx_credit  (net_rx_credit),
        .rpc_out        (rpc_out),
        .rpc_out_credit (rpc_out_credit)
    );

    initial begin
        ccip_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ccip_clk = ~ccip_clk;
    end

    // Mirrors the rate window phase, counted from reset release
    always @(posedge ccip_clk) begin
        if (reset) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    // ====================
    // Output monitors
    // ====================
    always @(negedge ccip_clk) begin
        if (!reset) begin
            if (net_tx.valid) begin
                net_q.push_back(net_tx);
            end
            if (rpc_out.valid) begin
                host_q.push_back(rpc_out);
            end
            if (rpc_in_credit) begin
                host_credits++;
                rpc_in_credit_cnt++;
            end
            if (net_rx_credit) begin
                net_credits++;
                net_rx_credit_cnt++;
            end
        end
    end

    always @(posedge ccip_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout, run stopped after %0d cycles", cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h87a7));
        errors            = 0;
        checks            = 0;
        cycle_cnt         = 0;
        host_credits      = RPC_FIFO_DEPTH;
        net_credits       = RPC_FIFO_DEPTH;
        rpc_in_sent       = 0;
        net_rx_sent       = 0;
        rpc_in_credit_cnt = 0;
        net_rx_credit_cnt = 0;
        next_tid          = '0;
        reset             = 1'b1;
        mmio_req          = '0;
        rpc_in            = '0;
        net_tx_credit     = 1'b0;
        net_rx            = '0;
        rpc_out_credit    = 1'b0;

        repeat (4) @(posedge ccip_clk);
        reset <= 1'b0;
        @(posedge ccip_clk);

        test_identification();
        test_sequencing();
        test_tx_path();
        test_rx_path();
        test_counters();
        test_rate();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
